//--- Makefile
TOP = tb_sram_subsystem
OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		-f compile.f --top-module $(TOP) --Mdir $(OBJ) -o $(TOP)

# pass only if the simulation printed the pass line
run: compile
	@out="$$(./$(OBJ)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ)

//--- compile.f
+incdir+include
rtl/sram_pkg.sv
rtl/sram_bus_if.sv
rtl/bus_adapter.sv
rtl/sram_controller.sv
rtl/sram_timing_regs.sv
rtl/sram_subsystem.sv
verif/sram_model.sv
verif/tb_sram_subsystem.sv

//--- include/sram_cfg.svh
`ifndef SRAM_CFG_SVH
`define SRAM_CFG_SVH

// host side byte address
`define SRAM_BYTE_ADDR_BITS 26

// word address on the sram pins
`define SRAM_WORD_ADDR_BITS 20

// extra cycles per sram access
`define SRAM_WAIT_BITS 4

// slow enough for common 10 ns parts at the default clock
`define SRAM_WAIT_RESET 2

`endif

//--- rtl/bus_adapter.sv
`timescale 1ns/1ns

module bus_adapter (
    input  logic                 clock,
    input  logic                 reset,
    input  sram_pkg::byte_addr_t slave_address,
    input  logic                 slave_read,
    input  logic                 slave_write,
    input  sram_pkg::word_t      slave_writedata,
    output sram_pkg::word_t      slave_readdata,
    output logic                 slave_readdatavalid,
    output logic                 slave_waitrequest,
    sram_bus_if.host             mem
);
    import sram_pkg::*;

    typedef enum logic [2:0] {
        RD_IDLE, RD_ISSUE1, RD_ISSUE2, RD_CHECK1, RD_CHECK2
    } rd_state_t;

    typedef enum logic [2:0] {
        WR_IDLE, WR_ISSUE1, WR_ISSUE2, WR_CHECK1, WR_CHECK2
    } wr_state_t;

    typedef enum logic {RX_FIRST, RX_SECOND} rx_state_t;

    rd_state_t  rd_state;
    rd_state_t  rd_retry;
    wr_state_t  wr_state;
    wr_state_t  wr_retry;
    rx_state_t  rx_state;

    logic       rd_busy;
    logic       wr_busy;
    logic       rd_strobe;
    logic       wr_strobe;
    logic       rd_second;
    logic       wr_second;
    byte_addr_t rd_base;
    byte_addr_t wr_base;
    byte_addr_t rd_addr;
    byte_addr_t wr_addr;
    word_t      wr_word;
    half_t      rx_low;
    logic       host_rd_accept;
    logic       host_wr_accept;
    logic       rx_last;

    assign host_rd_accept = slave_read && !slave_waitrequest;
    assign host_wr_accept = slave_write && !slave_waitrequest;
    assign rx_last = mem.readdatavalid && (rx_state == RX_SECOND);

    assign slave_waitrequest = rd_busy | wr_busy;

    // second beat goes to base + 2, little-endian halves
    assign rd_addr = rd_second ? rd_base + byte_addr_t'(2) : rd_base;
    assign wr_addr = wr_second ? wr_base + byte_addr_t'(2) : wr_base;

    assign mem.read      = rd_strobe;
    assign mem.write     = wr_strobe;
    assign mem.address   = wr_strobe ? wr_addr : rd_addr;
    assign mem.writedata = wr_second ? wr_word[31:16] : wr_word[15:0];

    // command cache
    always_ff @(posedge clock) begin
        if (host_rd_accept)
            rd_base <= slave_address;
        if (host_wr_accept) begin
            wr_base <= slave_address;
            wr_word <= slave_writedata;
        end
    end

    // read sequencer, busy held until the assembled word leaves
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            rd_state  <= RD_IDLE;
            rd_retry  <= RD_ISSUE1;
            rd_strobe <= 1'b0;
            rd_second <= 1'b0;
            rd_busy   <= 1'b0;
        end else begin
            rd_strobe <= 1'b0;
            if (rx_last)
                rd_busy <= 1'b0;
            case (rd_state)
                RD_IDLE: begin
                    if (host_rd_accept) begin
                        rd_busy   <= 1'b1;
                        rd_second <= 1'b0;
                        rd_retry  <= RD_ISSUE1;
                        if (!mem.waitrequest) begin
                            rd_strobe <= 1'b1;
                            rd_state  <= RD_CHECK1;
                        end else begin
                            rd_state <= RD_ISSUE1;
                        end
                    end
                end
                RD_ISSUE1: begin
                    if (!mem.waitrequest) begin
                        rd_strobe <= 1'b1;
                        rd_second <= 1'b0;
                        rd_retry  <= RD_ISSUE1;
                        rd_state  <= RD_CHECK1;
                    end
                end
                RD_ISSUE2: begin
                    if (!mem.waitrequest) begin
                        rd_strobe <= 1'b1;
                        rd_second <= 1'b1;
                        rd_retry  <= RD_ISSUE2;
                        rd_state  <= RD_CHECK2;
                    end
                end
                RD_CHECK1: begin
                    if (mem.waitrequest) begin
                        rd_state <= rd_retry;
                    end else begin
                        // first half taken, try the second right away
                        rd_strobe <= 1'b1;
                        rd_second <= 1'b1;
                        rd_retry  <= RD_ISSUE2;
                        rd_state  <= RD_CHECK2;
                    end
                end
                RD_CHECK2: begin
                    if (mem.waitrequest)
                        rd_state <= rd_retry;
                    else
                        rd_state <= RD_IDLE;
                end
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    // write sequencer
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            wr_state  <= WR_IDLE;
            wr_retry  <= WR_ISSUE1;
            wr_strobe <= 1'b0;
            wr_second <= 1'b0;
            wr_busy   <= 1'b0;
        end else begin
            wr_strobe <= 1'b0;
            case (wr_state)
                WR_IDLE: begin
                    if (host_wr_accept) begin
                        wr_busy   <= 1'b1;
                        wr_second <= 1'b0;
                        wr_retry  <= WR_ISSUE1;
                        if (!mem.waitrequest) begin
                            wr_strobe <= 1'b1;
                            wr_state  <= WR_CHECK1;
                        end else begin
                            wr_state <= WR_ISSUE1;
                        end
                    end
                end
                WR_ISSUE1: begin
                    if (!mem.waitrequest) begin
                        wr_strobe <= 1'b1;
                        wr_second <= 1'b0;
                        wr_retry  <= WR_ISSUE1;
                        wr_state  <= WR_CHECK1;
                    end
                end
                WR_ISSUE2: begin
                    if (!mem.waitrequest) begin
                        wr_strobe <= 1'b1;
                        wr_second <= 1'b1;
                        wr_retry  <= WR_ISSUE2;
                        wr_state  <= WR_CHECK2;
                    end
                end
                WR_CHECK1: begin
                    if (mem.waitrequest) begin
                        wr_state <= wr_retry;
                    end else begin
                        wr_strobe <= 1'b1;
                        wr_second <= 1'b1;
                        wr_retry  <= WR_ISSUE2;
                        wr_state  <= WR_CHECK2;
                    end
                end
                WR_CHECK2: begin
                    if (mem.waitrequest) begin
                        wr_state <= wr_retry;
                    end else begin
                        wr_busy  <= 1'b0;
                        wr_state <= WR_IDLE;
                    end
                end
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    // receive stage, low half first
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            rx_state            <= RX_FIRST;
            slave_readdatavalid <= 1'b0;
        end else begin
            slave_readdatavalid <= 1'b0;
            if (mem.readdatavalid) begin
                if (rx_state == RX_FIRST) begin
                    rx_state <= RX_SECOND;
                end else begin
                    rx_state            <= RX_FIRST;
                    slave_readdatavalid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (mem.readdatavalid) begin
            if (rx_state == RX_FIRST)
                rx_low <= mem.readdata;
            else
                slave_readdata <= {mem.readdata, rx_low};
        end
    end

    host_one_cmd: assert property (@(posedge clock) disable iff (!reset)
        !(slave_read && slave_write));

    mem_one_strobe: assert property (@(posedge clock) disable iff (!reset)
        !(mem.read && mem.write));

endmodule

//--- rtl/sram_bus_if.sv
`timescale 1ns/1ns

interface sram_bus_if;
    import sram_pkg::*;

    // request, driven by the adapter
    byte_addr_t address;
    logic       read;
    logic       write;
    half_t      writedata;

    // response, driven by the controller
    half_t      readdata;
    logic       readdatavalid;
    logic       waitrequest;

    modport host (
        output address,
        output read,
        output write,
        output writedata,
        input  readdata,
        input  readdatavalid,
        input  waitrequest
    );

    modport agent (
        input  address,
        input  read,
        input  write,
        input  writedata,
        output readdata,
        output readdatavalid,
        output waitrequest
    );

endinterface

//--- rtl/sram_controller.sv
`timescale 1ns/1ns
`include "sram_cfg.svh"

module sram_controller (
    input  logic                 clock,
    input  logic                 reset,
    sram_bus_if.agent            bus,
    input  sram_pkg::wait_t      wait_states,
    output logic                 idle,
    output sram_pkg::word_addr_t sram_addr,
    output sram_pkg::half_t      sram_dq_out,
    input  sram_pkg::half_t      sram_dq_in,
    output logic                 sram_dq_oe,
    output logic                 sram_ce_n,
    output logic                 sram_we_n,
    output logic                 sram_oe_n,
    output logic                 sram_lb_n,
    output logic                 sram_ub_n
);
    import sram_pkg::*;

    typedef enum logic {S_IDLE, S_ACCESS} state_t;

    state_t state;
    wait_t  count;
    logic   op_read;
    logic   accept;
    logic   last_cycle;

    assign accept     = (bus.read || bus.write) && !bus.waitrequest;
    assign last_cycle = (state == S_ACCESS) && (count == '0);
    assign idle       = (state == S_IDLE);

    // full word accesses, both lanes follow chip select
    assign sram_lb_n = sram_ce_n;
    assign sram_ub_n = sram_ce_n;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state             <= S_IDLE;
            count             <= '0;
            op_read           <= 1'b0;
            bus.waitrequest   <= 1'b0;
            bus.readdatavalid <= 1'b0;
            sram_ce_n         <= 1'b1;
            sram_we_n         <= 1'b1;
            sram_oe_n         <= 1'b1;
            sram_dq_oe        <= 1'b0;
        end else begin
            bus.readdatavalid <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        // count fixed here so a new wait value waits for the next access
                        state           <= S_ACCESS;
                        count           <= wait_states;
                        op_read         <= bus.read;
                        bus.waitrequest <= 1'b1;
                        sram_ce_n       <= 1'b0;
                        sram_we_n       <= !bus.write;
                        sram_oe_n       <= !bus.read;
                        sram_dq_oe      <= bus.write;
                    end
                end
                S_ACCESS: begin
                    if (count == '0) begin
                        state             <= S_IDLE;
                        bus.waitrequest   <= 1'b0;
                        bus.readdatavalid <= op_read;
                        sram_ce_n         <= 1'b1;
                        sram_we_n         <= 1'b1;
                        sram_oe_n         <= 1'b1;
                        sram_dq_oe        <= 1'b0;
                    end else begin
                        count <= count - wait_t'(1);
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // address and data held for the whole access
    always_ff @(posedge clock) begin
        if (accept) begin
            sram_addr   <= bus.address[`SRAM_WORD_ADDR_BITS:1];
            sram_dq_out <= bus.writedata;
        end
        if (last_cycle && op_read)
            bus.readdata <= sram_dq_in;
    end

    no_accept_when_busy: assert property (@(posedge clock) disable iff (!reset)
        accept |-> idle);

endmodule

//--- rtl/sram_pkg.sv
`include "sram_cfg.svh"

package sram_pkg;

    // one sram data word
    typedef logic [15:0] half_t;

    // one host data word, two sram words
    typedef logic [31:0] word_t;

    // host byte address
    typedef logic [`SRAM_BYTE_ADDR_BITS-1:0] byte_addr_t;

    // sram word address, byte address without bit 0
    typedef logic [`SRAM_WORD_ADDR_BITS-1:0] word_addr_t;

    // extra cycles added to every access
    typedef logic [`SRAM_WAIT_BITS-1:0] wait_t;

endpackage

//--- rtl/sram_subsystem.sv
`timescale 1ns/1ns

module sram_subsystem (
    input  logic                 clock,
    input  logic                 reset,
    input  sram_pkg::byte_addr_t slave_address,
    input  logic                 slave_read,
    input  logic                 slave_write,
    input  sram_pkg::word_t      slave_writedata,
    output sram_pkg::word_t      slave_readdata,
    output logic                 slave_readdatavalid,
    output logic                 slave_waitrequest,
    input  logic                 cfg_write,
    input  sram_pkg::wait_t      cfg_writedata,
    output sram_pkg::wait_t      cfg_readdata,
    output sram_pkg::word_addr_t sram_addr,
    output sram_pkg::half_t      sram_dq_out,
    input  sram_pkg::half_t      sram_dq_in,
    output logic                 sram_dq_oe,
    output logic                 sram_ce_n,
    output logic                 sram_we_n,
    output logic                 sram_oe_n,
    output logic                 sram_lb_n,
    output logic                 sram_ub_n
);
    import sram_pkg::*;

    wait_t wait_states;
    logic  idle;

    sram_bus_if mem_bus ();

    bus_adapter u_adapter (
        .clock               (clock),
        .reset               (reset),
        .slave_address       (slave_address),
        .slave_read          (slave_read),
        .slave_write         (slave_write),
        .slave_writedata     (slave_writedata),
        .slave_readdata      (slave_readdata),
        .slave_readdatavalid (slave_readdatavalid),
        .slave_waitrequest   (slave_waitrequest),
        .mem                 (mem_bus)
    );

    sram_controller u_controller (
        .clock       (clock),
        .reset       (reset),
        .bus         (mem_bus),
        .wait_states (wait_states),
        .idle        (idle),
        .sram_addr   (sram_addr),
        .sram_dq_out (sram_dq_out),
        .sram_dq_in  (sram_dq_in),
        .sram_dq_oe  (sram_dq_oe),
        .sram_ce_n   (sram_ce_n),
        .sram_we_n   (sram_we_n),
        .sram_oe_n   (sram_oe_n),
        .sram_lb_n   (sram_lb_n),
        .sram_ub_n   (sram_ub_n)
    );

    sram_timing_regs u_timing (
        .clock         (clock),
        .reset         (reset),
        .cfg_write     (cfg_write),
        .cfg_writedata (cfg_writedata),
        .cfg_readdata  (cfg_readdata),
        .idle          (idle),
        .wait_states   (wait_states)
    );

endmodule

//--- rtl/sram_timing_regs.sv
`timescale 1ns/1ns
`include "sram_cfg.svh"

module sram_timing_regs (
    input  logic            clock,
    input  logic            reset,
    input  logic            cfg_write,
    input  sram_pkg::wait_t cfg_writedata,
    output sram_pkg::wait_t cfg_readdata,
    input  logic            idle,
    output sram_pkg::wait_t wait_states
);
    import sram_pkg::*;

    wait_t pending;
    logic  pending_valid;

    // readback shows the last value written, applied or not
    assign cfg_readdata = pending;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            pending       <= wait_t'(`SRAM_WAIT_RESET);
            pending_valid <= 1'b0;
            wait_states   <= wait_t'(`SRAM_WAIT_RESET);
        end else if (cfg_write) begin
            // a newer write replaces one not yet applied
            pending       <= cfg_writedata;
            pending_valid <= 1'b1;
        end else if (pending_valid && idle) begin
            wait_states   <= pending;
            pending_valid <= 1'b0;
        end
    end

    wait_change_when_idle: assert property (@(posedge clock) disable iff (!reset)
        (wait_states != $past(wait_states)) |-> $past(idle));

endmodule

//--- verif/sram_model.sv
`timescale 1ns/1ns
`include "sram_cfg.svh"

module sram_model (
    input  sram_pkg::word_addr_t sram_addr,
    input  sram_pkg::half_t      sram_dq_out,
    output sram_pkg::half_t      sram_dq_in,
    input  logic                 sram_dq_oe,
    input  logic                 sram_ce_n,
    input  logic                 sram_we_n,
    input  logic                 sram_oe_n,
    input  logic                 sram_lb_n,
    input  logic                 sram_ub_n
);
    import sram_pkg::*;

    localparam int DEPTH = 1 << `SRAM_WORD_ADDR_BITS;

    half_t mem [DEPTH];

    logic  selected;
    logic  writing;
    logic  reading;

    assign selected = !sram_ce_n;
    assign writing  = selected && !sram_we_n && sram_dq_oe;
    assign reading  = selected && !sram_oe_n && sram_we_n;

    // data only driven while the part is read
    assign sram_dq_in = reading ? mem[sram_addr] : '0;

    // level sensitive write, each byte lane on its own enable
    always @(writing or sram_addr or sram_dq_out or sram_lb_n or sram_ub_n) begin
        if (writing) begin
            if (!sram_lb_n)
                mem[sram_addr][7:0] = sram_dq_out[7:0];
            if (!sram_ub_n)
                mem[sram_addr][15:8] = sram_dq_out[15:8];
        end
    end

endmodule

//--- verif/tb_sram_subsystem.sv
`timescale 1ns/1ns
`include "sram_cfg.svh"

module tb_sram_subsystem;
    import sram_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int WR_N         = 10;
    localparam int RD_N         = 10;
    localparam int B2B_N        = 8;
    // three wait phases, four commands around the config write, then the pairs
    localparam int N_CMDS       = 3 * (WR_N + RD_N) + 4 + 2 * B2B_N;
    localparam int CYCLE_LIMIT  = 64 * N_CMDS + RESET_CYCLES;

    logic       clock;
    logic       reset;
    byte_addr_t slave_address;
    logic       slave_read;
    logic       slave_write;
    word_t      slave_writedata;
    word_t      slave_readdata;
    logic       slave_readdatavalid;
    logic       slave_waitrequest;
    logic       cfg_write;
    wait_t      cfg_writedata;
    wait_t      cfg_readdata;
    word_addr_t sram_addr;
    half_t      sram_dq_out;
    half_t      sram_dq_in;
    logic       sram_dq_oe;
    logic       sram_ce_n;
    logic       sram_we_n;
    logic       sram_oe_n;
    logic       sram_lb_n;
    logic       sram_ub_n;

    integer     seed;
    int         value_errors;
    int         other_errors;
    int         cycle_count;
    int         reads_issued;
    int         responses;
    int         last_cycles;
    word_t      popped;
    word_t      expect_q[$];
    half_t      shadow [64];

    sram_subsystem i_dut (.*);

    sram_model i_model (.*);

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles with the host port still busy", cycle_count);
            $display("errors: value %0d, other %0d", value_errors, other_errors);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input word_t got, input word_t expected);
        assert (got == expected) else begin
            $display("[ERROR] %s expected 0x%h got 0x%h", name, expected, got);
            value_errors++;
        end
    endtask

    task automatic check_condition(input bit ok, input string what);
        assert (ok) else begin
            $display("%s", what);
            other_errors++;
        end
    endtask

    // expected read value, low half at the base word and high half at the next
    function automatic word_t expected_word(input byte_addr_t addr);
        int w;
        w = int'(addr >> 1);
        return {shadow[w + 1], shadow[w]};
    endfunction

    // responses sampled mid-cycle
    always @(negedge clock) begin
        if (reset && slave_readdatavalid) begin
            responses++;
            if (expect_q.size() == 0) begin
                $display("read response arrived with no read outstanding");
                other_errors++;
            end else begin
                popped = expect_q.pop_front();
                check_value("slave_readdata", slave_readdata, popped);
            end
        end
    end

    // strobe once the port is free, return when the command is done
    task automatic host_command(input bit is_write, input byte_addr_t addr,
                                input word_t data, output int cycles);
        while (slave_waitrequest) begin
            @(posedge clock);
            #1;
        end
        slave_address   = addr;
        slave_writedata = data;
        slave_write     = is_write;
        slave_read      = !is_write;
        @(posedge clock);
        #1;
        slave_read  = 1'b0;
        slave_write = 1'b0;
        cycles      = 1;
        while (slave_waitrequest) begin
            @(posedge clock);
            #1;
            cycles++;
        end
    endtask

    task automatic host_write(input byte_addr_t addr, input word_t data);
        int w;
        w = int'(addr >> 1);
        shadow[w]     = data[15:0];
        shadow[w + 1] = data[31:16];
        host_command(1'b1, addr, data, last_cycles);
    endtask

    task automatic host_read(input byte_addr_t addr);
        expect_q.push_back(expected_word(addr));
        reads_issued++;
        host_command(1'b0, addr, '0, last_cycles);
    endtask

    // second half is still on the pins when the host sees completion
    task automatic check_placement(input byte_addr_t addr, input word_t data);
        word_addr_t w;
        w = word_addr_t'(addr >> 1);
        while (!sram_ce_n) begin
            @(posedge clock);
            #1;
        end
        check_value($sformatf("i_model.mem[%0d]", w), word_t'(i_model.mem[w]),
                    word_t'(data[15:0]));
        check_value($sformatf("i_model.mem[%0d]", w + 1),
                    word_t'(i_model.mem[w + word_addr_t'(1)]), word_t'(data[31:16]));
    endtask

    task automatic write_config(input wait_t value);
        cfg_writedata = value;
        cfg_write     = 1'b1;
        @(posedge clock);
        #1;
        cfg_write = 1'b0;
        check_value("cfg_readdata", word_t'(cfg_readdata), word_t'(value));
    endtask

    task automatic set_wait(input wait_t value);
        write_config(value);
        while (!sram_ce_n) begin
            @(posedge clock);
            #1;
        end
        @(posedge clock);
        #1;
    endtask

    task automatic run_phase(input wait_t value, output int fastest, output int slowest);
        byte_addr_t addrs [WR_N];
        word_t      data;
        int         idx;
        set_wait(value);
        fastest = CYCLE_LIMIT;
        slowest = 0;
        for (int i = 0; i < WR_N + RD_N; i++) begin
            if (i < WR_N) begin
                addrs[i] = byte_addr_t'($unsigned($random(seed)) & 32'h3e);
                data     = $random(seed);
                host_write(addrs[i], data);
            end else begin
                idx = $unsigned($random(seed)) % WR_N;
                host_read(addrs[idx]);
            end
            if (last_cycles < fastest)
                fastest = last_cycles;
            if (last_cycles > slowest)
                slowest = last_cycles;
            if (i < WR_N)
                check_placement(addrs[i], data);
        end
    endtask

    task automatic config_during_traffic();
        word_t data;
        data = $random(seed);
        fork
            host_write(26'h10, data);
            begin
                repeat (3) @(posedge clock);
                #1;
                check_condition(slave_waitrequest, "cfg_write was not issued during a command");
                write_config(wait_t'(1));
            end
        join
        check_placement(26'h10, data);
        host_read(26'h10);
        data = $random(seed);
        host_write(26'h14, data);
        host_read(26'h14);
    endtask

    initial begin
        int fast_d;
        int slow_d;
        int fast_0;
        int slow_0;
        int fast_15;
        int slow_15;
        seed            = 32'hff50;
        clock           = 1'b0;
        reset           = 1'b0;
        slave_address   = '0;
        slave_read      = 1'b0;
        slave_write     = 1'b0;
        slave_writedata = '0;
        cfg_write       = 1'b0;
        cfg_writedata   = '0;
        value_errors    = 0;
        other_errors    = 0;
        cycle_count     = 0;
        reads_issued    = 0;
        responses       = 0;
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        reset = 1'b1;

        check_value("slave_waitrequest", word_t'(slave_waitrequest), 32'h0);
        check_value("slave_readdatavalid", word_t'(slave_readdatavalid), 32'h0);
        check_value("sram_ce_n", word_t'(sram_ce_n), 32'h1);
        check_value("sram_we_n", word_t'(sram_we_n), 32'h1);
        check_value("sram_oe_n", word_t'(sram_oe_n), 32'h1);
        check_value("sram_lb_n", word_t'(sram_lb_n), 32'h1);
        check_value("sram_ub_n", word_t'(sram_ub_n), 32'h1);
        check_value("sram_dq_oe", word_t'(sram_dq_oe), 32'h0);
        check_value("cfg_readdata", word_t'(cfg_readdata), word_t'(`SRAM_WAIT_RESET));

        run_phase(wait_t'(`SRAM_WAIT_RESET), fast_d, slow_d);
        run_phase(wait_t'(0), fast_0, slow_0);
        run_phase(wait_t'(15), fast_15, slow_15);
        check_condition(fast_15 > slow_0, "commands at wait count 15 were not slower than at 0");
        check_condition(fast_d > fast_0 && slow_d > slow_0,
                        "commands at the reset wait count were not slower than at 0");
        check_condition(fast_15 > fast_d && slow_15 > slow_d,
                        "commands at wait count 15 were not slower than at the reset count");

        config_during_traffic();

        // next command strobed in the first free cycle
        for (int i = 0; i < B2B_N; i++) begin
            host_write(26'h22, $random(seed));
            host_read(26'h22);
        end

        @(negedge clock);
        #1;
        check_condition(expect_q.size() == 0, "read responses missing at the end of the run");
        check_condition(responses == reads_issued, "response count differs from read count");

        $display("errors: value %0d, other %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule
